/* design/mipsIsaPkg.sv */
package mipsIsaPkg;

    // Instructions the memory stage handles differently
    typedef enum logic [3:0] {
        opNop,
        opLw,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opSw,
        opSh,
        opSb,
        opMfc0,
        opMtc0,
        opEret,
        opAlu
    } memOp;

    // Cause.ExcCode, INT and NONE share a value and the flag tells them apart
    typedef logic [4:0] excCode;
    localparam excCode excInt  = 5'd0;
    localparam excCode excAdel = 5'd4;
    localparam excCode excAdes = 5'd5;
    localparam excCode excNone = 5'd0;

    // Request to the pipeline controller
    typedef enum logic [1:0] {
        kcNone,
        kcKtext,
        kcEret
    } kernelCtrl;

    // Exception handler address
    localparam logic [31:0] kernelEntry = 32'h0000_4180;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFields;

    // Instruction word seen as R-format or I-format
    typedef union packed {
        rFields r;
        iFields i;
    } instrWord;

    typedef struct packed {
        memOp        op;
        instrWord    instr;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] rtData;
        logic [4:0]  rtAddr;
        logic [4:0]  destAddr;
        logic [31:0] destData;
        excCode      excIn;
        logic        hasExc;
        logic        inDelaySlot;
    } memReq;

    // Value being written back this cycle
    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
    } wbFwd;

    typedef struct packed {
        memOp        op;
        logic [31:0] pc;
        logic [4:0]  destAddr;
        logic [31:0] regData;
        logic [31:0] memWord;
        logic [1:0]  offset;
        logic        noWrite;
    } wbEntry;

endpackage

/* design/memMapPkg.sv */
package memMapPkg;

    // Data RAM window
    localparam logic [31:0] dataStart = 32'h0000_0000;
    localparam logic [31:0] dataEnd   = 32'h0000_2FFF;

    // Peripheral windows, end addresses inclusive
    localparam logic [31:0] timer0Start = 32'h0000_7F00;
    localparam logic [31:0] timer0End   = 32'h0000_7F0B;
    localparam logic [31:0] timer1Start = 32'h0000_7F10;
    localparam logic [31:0] timer1End   = 32'h0000_7F1B;
    localparam logic [31:0] ledAddr     = 32'h0000_7F20;
    localparam logic [31:0] tubeAddr    = 32'h0000_7F24;
    localparam logic [31:0] switchAddr  = 32'h0000_7F28;
    localparam logic [31:0] buzzerStart = 32'h0000_7F30;
    localparam logic [31:0] buzzerEnd   = 32'h0000_7F3F;

    // Timer count registers cannot be stored to
    localparam logic [31:0] roAddr0 = 32'h0000_7F08;
    localparam logic [31:0] roAddr1 = 32'h0000_7F18;

    localparam logic [4:0] cp0Sr    = 5'd12;
    localparam logic [4:0] cp0Cause = 5'd13;
    localparam logic [4:0] cp0Epc   = 5'd14;
    localparam logic [4:0] cp0PrId  = 5'd15;

    localparam logic [31:0] prIdValue = 32'h0001_8A05;
    localparam logic [31:0] epcReset  = 32'h0000_3000;

    localparam int ramWords    = 3072;
    localparam int ramAddrBits = 12;

endpackage

/* design/storeLanes.sv */
`timescale 1ns/1ps

module storeLanes (
    input  mipsIsaPkg::memOp   op,
    input  logic [31:0]        addr,
    input  logic [31:0]        storeData,
    output logic [3:0]         byteEn,
    output logic [31:0]        laneData,
    output logic [1:0]         offset,
    output logic               fault,
    output mipsIsaPkg::excCode faultCode
);
    import mipsIsaPkg::*;
    import memMapPkg::*;

    logic isLoad;
    logic isStore;
    logic isWordOp;
    logic isHalfOp;
    logic isSubWord;
    logic misaligned;
    logic inData;
    logic mapped;
    logic readOnly;

    function automatic logic inWindow(input logic [31:0] a, input logic [31:0] lo,
                                      input logic [31:0] hi);
        return (a >= lo) && (a <= hi);
    endfunction

    assign isLoad    = op inside {opLw, opLh, opLhu, opLb, opLbu};
    assign isStore   = op inside {opSw, opSh, opSb};
    assign isWordOp  = op inside {opLw, opSw};
    assign isHalfOp  = op inside {opLh, opLhu, opSh};
    assign isSubWord = op inside {opLh, opLhu, opLb, opLbu, opSh, opSb};

    assign offset = addr[1:0];

    assign misaligned = (isWordOp && addr[1:0] != 2'b00) || (isHalfOp && addr[0]);
    assign inData     = inWindow(addr, dataStart, dataEnd);

    // Every legal target, peripherals included
    assign mapped = inData
                 || inWindow(addr, timer0Start, timer0End)
                 || inWindow(addr, timer1Start, timer1End)
                 || addr == ledAddr
                 || addr == tubeAddr
                 || addr == switchAddr
                 || inWindow(addr, buzzerStart, buzzerEnd);

    assign readOnly = isStore && (addr == roAddr0 || addr == roAddr1);

    // Sub-word accesses only make sense inside the RAM
    assign fault = (isLoad || isStore)
                && (misaligned || !mapped || (isSubWord && !inData) || readOnly);
    assign faultCode = isStore ? excAdes : excAdel;

    always_comb begin
        case (op)
            opSw:    byteEn = 4'b1111;
            opSh:    byteEn = addr[1] ? 4'b1100 : 4'b0011;
            opSb:    byteEn = 4'b0001 << addr[1:0];
            default: byteEn = 4'b0000;
        endcase
    end

    // Move the low bytes up to the addressed lane
    always_comb begin
        case (op)
            opSh:    laneData = storeData << {addr[1], 4'b0000};
            opSb:    laneData = storeData << {addr[1:0], 3'b000};
            default: laneData = storeData;
        endcase
    end

endmodule

/* design/cp0Regs.sv */
`timescale 1ns/1ps

module cp0Regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  fire,
    input  mipsIsaPkg::memOp      op,
    input  logic [4:0]            cp0Id,
    input  logic [31:0]           wData,
    input  mipsIsaPkg::excCode    exc,
    input  logic                  hasExc,
    input  logic [31:0]           pc,
    input  logic                  inDelaySlot,
    input  logic [5:0]            hwInt,
    output logic [31:0]           rData,
    output mipsIsaPkg::kernelCtrl kCtrl,
    output logic                  takeTrap,
    output logic [29:0]           epc,
    output logic                  bd
);
    import mipsIsaPkg::*;
    import memMapPkg::*;

    // SR fields
    logic [5:0]  im;
    logic        exl;
    logic        ie;
    // Cause fields
    logic [5:0]  ip;
    excCode      causeCode;
    logic        bdReg;
    logic [29:0] epcReg;

    logic        intPending;
    logic        trapEntry;
    logic        eretFire;
    logic        mtc0Fire;
    logic [31:0] trapPc;
    logic [31:0] srWord;
    logic [31:0] causeWord;

    assign intPending = |(hwInt & im) && ie && !exl;
    assign takeTrap   = intPending || hasExc;

    // A trap outranks ERET and MTC0 in the same instruction
    assign trapEntry = fire && takeTrap;
    assign eretFire  = fire && !takeTrap && op == opEret;
    assign mtc0Fire  = fire && !takeTrap && op == opMtc0;

    // Restart at the branch when the victim sits in its delay slot
    assign trapPc = inDelaySlot ? pc - 32'd4 : pc;

    assign srWord    = {16'b0, im, 8'b0, exl, ie};
    assign causeWord = {bdReg, 15'b0, ip, 3'b0, causeCode, 2'b00};

    always_comb begin
        case (cp0Id)
            cp0Sr:    rData = srWord;
            cp0Cause: rData = causeWord;
            cp0Epc:   rData = {epcReg, 2'b00};
            cp0PrId:  rData = prIdValue;
            default:  rData = '0;
        endcase
    end

    assign kCtrl = trapEntry ? kcKtext : (eretFire ? kcEret : kcNone);
    assign epc   = trapEntry ? trapPc[31:2] : epcReg;
    assign bd    = trapEntry && inDelaySlot;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            im        <= '1;
            exl       <= 1'b0;
            ie        <= 1'b1;
            ip        <= '0;
            causeCode <= excNone;
            bdReg     <= 1'b0;
            epcReg    <= epcReset[31:2];
        end else if (trapEntry) begin
            exl       <= 1'b1;
            causeCode <= intPending ? excInt : exc;
            ip        <= hwInt & im;
            bdReg     <= inDelaySlot;
            epcReg    <= trapPc[31:2];
        end else if (eretFire) begin
            exl       <= 1'b0;
            causeCode <= excNone;
            bdReg     <= 1'b0;
        end else if (mtc0Fire) begin
            if (cp0Id == cp0Sr) begin
                im  <= wData[15:10];
                exl <= wData[1];
                ie  <= wData[0];
            end else if (cp0Id == cp0Epc) begin
                epcReg <= wData[31:2];
            end
        end
    end

    kTextOnlyOnFire: assert property (@(posedge clk) disable iff (!rst_n)
        !fire |-> kCtrl != kcKtext)
        else $error("kCtrl requested handler entry without an accepted instruction");

endmodule

/* design/dataRam.sv */
`timescale 1ns/1ps

module dataRam (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [29:0] ramAddr,
    input  logic [3:0]  ramWe,
    input  logic [31:0] ramWData,
    output logic [31:0] ramRData
);
    import memMapPkg::*;

    logic [31:0]            mem [ramWords];
    logic                   inArray;
    logic [ramAddrBits-1:0] idx;

    assign inArray = ramAddr < 30'(ramWords);
    assign idx     = ramAddr[ramAddrBits-1:0];

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (inArray) begin
            for (int b = 0; b < 4; b++) begin
                if (ramWe[b]) begin
                    mem[idx][8*b +: 8] <= ramWData[8*b +: 8];
                end
            end
        end
    end

    // Words past the array read as zero
    assign ramRData = inArray ? mem[idx] : '0;

    weInsideArray: assert property (@(posedge clk) disable iff (!rst_n)
        !inArray |-> ramWe == 4'b0000)
        else $error("RAM write enabled for a word beyond the array");

endmodule

/* design/memStage.sv */
`timescale 1ns/1ps

module memStage (
    input  logic               clk,
    input  logic               rst_n,
    input  mipsIsaPkg::memReq  memIn,
    input  logic               inValid,
    output logic               inReady,
    input  mipsIsaPkg::wbFwd   fwd,
    input  logic               flush,
    output mipsIsaPkg::wbEntry wbOut,
    output logic               outValid,
    input  logic               outReady,
    output logic [29:0]        ramAddr,
    output logic [3:0]         ramWe,
    output logic [31:0]        ramWData,
    input  logic [31:0]        ramRData,
    output logic               cp0Fire,
    output mipsIsaPkg::memOp   cp0Op,
    output logic [4:0]         cp0Id,
    output logic [31:0]        cp0WData,
    output mipsIsaPkg::excCode excFinal,
    output logic               hasExcFinal,
    output logic [31:0]        cp0Pc,
    output logic               cp0InDelaySlot,
    input  logic [31:0]        cp0RData,
    input  logic               takeTrap
);
    import mipsIsaPkg::*;
    import memMapPkg::*;

    logic        fire;
    logic [31:0] rtUse;
    logic [3:0]  byteEn;
    logic [31:0] laneData;
    logic [1:0]  laneOffset;
    logic        laneFault;
    excCode      laneCode;
    logic        ramHit;
    logic        isLoad;
    wbEntry      nextEntry;

    assign inReady = !outValid || outReady;
    assign fire    = inValid && inReady;

    // Store operand bypass from writeback, r0 never forwards
    assign rtUse = (fwd.addr == memIn.rtAddr && fwd.addr != 5'd0) ? fwd.data : memIn.rtData;

    storeLanes lanes (
        .op        (memIn.op),
        .addr      (memIn.addr),
        .storeData (rtUse),
        .byteEn    (byteEn),
        .laneData  (laneData),
        .offset    (laneOffset),
        .fault     (laneFault),
        .faultCode (laneCode)
    );

    // Upstream fault is older and wins
    assign excFinal    = memIn.hasExc ? memIn.excIn : laneCode;
    assign hasExcFinal = memIn.hasExc || laneFault;

    // Flushed instructions leave CP0 alone
    assign cp0Fire        = fire && !flush;
    assign cp0Op          = memIn.op;
    assign cp0Id          = memIn.instr.r.rd;
    assign cp0WData       = rtUse;
    assign cp0Pc          = memIn.pc;
    assign cp0InDelaySlot = memIn.inDelaySlot;

    // Only the RAM window takes writes
    assign ramHit   = memIn.addr >= dataStart && memIn.addr <= dataEnd;
    assign ramAddr  = memIn.addr[31:2];
    assign ramWData = laneData;
    assign ramWe    = (cp0Fire && !takeTrap && ramHit) ? byteEn : 4'b0000;

    assign isLoad = memIn.op inside {opLw, opLh, opLhu, opLb, opLbu};

    always_comb begin
        nextEntry.op       = memIn.op;
        nextEntry.pc       = memIn.pc;
        nextEntry.destAddr = memIn.destAddr;
        if (memIn.op == opMfc0) begin
            nextEntry.regData = cp0RData;
        end else if (isLoad) begin
            nextEntry.regData = ramRData;
        end else begin
            nextEntry.regData = memIn.destData;
        end
        nextEntry.memWord  = ramRData;
        nextEntry.offset   = laneOffset;
        nextEntry.noWrite  = flush || takeTrap;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            wbOut <= nextEntry;
        end
    end

    holdUnderStall: assert property (@(posedge clk) disable iff (!rst_n)
        outValid && !outReady |=> outValid && $stable(wbOut))
        else $error("writeback entry changed while stalled");

    // Decode must place the store source in the I-format rt field
    storeRtMatches: assert property (@(posedge clk) disable iff (!rst_n)
        inValid && memIn.op inside {opSw, opSh, opSb} |-> memIn.instr.i.rt == memIn.rtAddr)
        else $error("store rtAddr disagrees with instruction rt field");

endmodule

/* design/memTop.sv */
`timescale 1ns/1ps

module memTop (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mipsIsaPkg::memReq     memIn,
    input  logic                  inValid,
    output logic                  inReady,
    input  mipsIsaPkg::wbFwd      fwd,
    input  logic                  flush,
    input  logic [5:0]            hwInt,
    output mipsIsaPkg::wbEntry    wbOut,
    output logic                  outValid,
    input  logic                  outReady,
    output mipsIsaPkg::kernelCtrl kCtrl,
    output logic [29:0]           epcOut,
    output logic                  bdOut
);
    import mipsIsaPkg::*;

    logic [29:0] ramAddr;
    logic [3:0]  ramWe;
    logic [31:0] ramWData;
    logic [31:0] ramRData;

    logic        cp0Fire;
    memOp        cp0Op;
    logic [4:0]  cp0Id;
    logic [31:0] cp0WData;
    excCode      excFinal;
    logic        hasExcFinal;
    logic [31:0] cp0Pc;
    logic        cp0InDelaySlot;
    logic [31:0] cp0RData;
    logic        takeTrap;

    memStage stage (
        .clk, .rst_n, .memIn, .inValid, .inReady, .fwd, .flush,
        .wbOut, .outValid, .outReady,
        .ramAddr, .ramWe, .ramWData, .ramRData,
        .cp0Fire, .cp0Op, .cp0Id, .cp0WData, .excFinal, .hasExcFinal,
        .cp0Pc, .cp0InDelaySlot, .cp0RData, .takeTrap
    );

    cp0Regs cp0 (
        .clk, .rst_n,
        .fire        (cp0Fire),
        .op          (cp0Op),
        .cp0Id       (cp0Id),
        .wData       (cp0WData),
        .exc         (excFinal),
        .hasExc      (hasExcFinal),
        .pc          (cp0Pc),
        .inDelaySlot (cp0InDelaySlot),
        .hwInt       (hwInt),
        .rData       (cp0RData),
        .kCtrl       (kCtrl),
        .takeTrap    (takeTrap),
        .epc         (epcOut),
        .bd          (bdOut)
    );

    dataRam ram (
        .clk, .rst_n, .ramAddr, .ramWe, .ramWData, .ramRData
    );

endmodule

/* bench/memTopTb.sv */
`timescale 1ns/1ps

module memTopTb;
    import mipsIsaPkg::*;
    import memMapPkg::*;

    localparam logic [31:0] base = 32'h0000_0200;
    localparam int waitLimit = 200;

    logic        clk;
    logic        rst_n;
    memReq       memIn;
    logic        inValid;
    logic        inReady;
    wbFwd        fwd;
    logic        flush;
    logic [5:0]  hwInt;
    wbEntry      wbOut;
    logic        outValid;
    logic        outReady;
    kernelCtrl   kCtrl;
    logic [29:0] epcOut;
    logic        bdOut;

    // Reference RAM image and CP0 state
    logic [31:0] mdl [ramWords];
    logic [5:0]  mIm;
    logic        mExl;
    logic        mIe;
    logic [5:0]  mIp;
    excCode      mCode;
    logic        mBd;
    logic [29:0] mEpc;
    kernelCtrl   expK;
    logic [29:0] expEpc;
    logic        expBd;

    wbEntry      expQ[$];
    wbEntry      popped;
    kernelCtrl   lastK;
    logic [29:0] lastEpc;
    logic [31:0] stimSeed;
    logic [31:0] gapSeed;
    logic [31:0] pcNext;
    logic        gapsOn;
    string       testName;
    int          checks;
    int          errors;
    int          tests;
    int          testChecks;
    int          testErrors;

    memTop DUT (
        .clk, .rst_n, .memIn, .inValid, .inReady, .fwd, .flush, .hwInt,
        .wbOut, .outValid, .outReady, .kCtrl, .epcOut, .bdOut
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] nextRand();
        stimSeed = lcgStep(stimSeed);
        return stimSeed;
    endfunction

    function automatic memReq buildReq(input memOp op, input logic [31:0] addr,
                                       input logic [4:0] rtAddr, input logic [31:0] rtData,
                                       input logic [4:0] cp0Num, input logic inDs);
        memReq r;
        r = '0;
        r.op = op;
        r.instr.i.rt = rtAddr;
        r.instr.i.imm = addr[15:0];
        if (op == opMfc0 || op == opMtc0) begin
            r.instr.r.rd = cp0Num;
        end
        r.pc = pcNext;
        pcNext = (pcNext == 32'h0000_3FFC) ? epcReset : pcNext + 32'd4;
        r.addr = addr;
        r.rtData = rtData;
        r.rtAddr = rtAddr;
        r.destAddr = 5'd3;
        r.destData = nextRand();
        r.inDelaySlot = inDs;
        return r;
    endfunction

    function automatic logic [31:0] cp0Read(input logic [4:0] id);
        case (id)
            cp0Sr:    return {16'b0, mIm, 8'b0, mExl, mIe};
            cp0Cause: return {mBd, 15'b0, mIp, 3'b0, mCode, 2'b00};
            cp0Epc:   return {mEpc, 2'b00};
            cp0PrId:  return prIdValue;
            default:  return 32'd0;
        endcase
    endfunction

    // Predicts the entry and kernel request, then advances the model
    function automatic wbEntry refStep(input memReq req, input logic fl);
        wbEntry      e;
        logic [31:0] a;
        logic [31:0] rt;
        logic [31:0] word;
        logic [31:0] trapPc;
        logic [11:0] wIdx;
        logic        isLd;
        logic        isSt;
        logic        inRam;
        logic        mapped;
        logic        bad;
        logic        intr;
        logic        trap;
        int          size;
        excCode      code;
        a = req.addr;
        rt = (fwd.addr == req.rtAddr && fwd.addr != 5'd0) ? fwd.data : req.rtData;
        isLd = req.op inside {opLw, opLh, opLhu, opLb, opLbu};
        isSt = req.op inside {opSw, opSh, opSb};
        size = (req.op inside {opLw, opSw}) ? 4 : ((req.op inside {opLh, opLhu, opSh}) ? 2 : 1);
        inRam = a <= dataEnd;
        mapped = inRam || (a >= timer0Start && a <= timer0End)
              || (a >= timer1Start && a <= timer1End) || a == ledAddr || a == tubeAddr
              || a == switchAddr || (a >= buzzerStart && a <= buzzerEnd);
        bad = (int'(a[1:0]) % size != 0) || !mapped || (size < 4 && !inRam)
           || (isSt && (a == roAddr0 || a == roAddr1));
        bad = bad && (isLd || isSt);
        code = req.hasExc ? req.excIn : (isSt ? excAdes : excAdel);
        intr = (|(hwInt & mIm)) && mIe && !mExl;
        trap = intr || req.hasExc || bad;
        wIdx = a[13:2];
        word = (a[31:2] < 30'(ramWords)) ? mdl[wIdx] : 32'd0;
        e.op = req.op;
        e.pc = req.pc;
        e.destAddr = req.destAddr;
        if (req.op == opMfc0) begin
            e.regData = cp0Read(req.instr.r.rd);
        end else if (isLd) begin
            e.regData = word;
        end else begin
            e.regData = req.destData;
        end
        e.memWord = word;
        e.offset = a[1:0];
        e.noWrite = fl || trap;
        trapPc = req.inDelaySlot ? req.pc - 32'd4 : req.pc;
        expK = kcNone;
        expEpc = mEpc;
        expBd = 1'b0;
        if (!fl && trap) begin
            expK = kcKtext;
            expEpc = trapPc[31:2];
            expBd = req.inDelaySlot;
            mExl = 1'b1;
            mCode = intr ? excInt : code;
            mIp = hwInt & mIm;
            mBd = req.inDelaySlot;
            mEpc = trapPc[31:2];
        end else if (!fl && req.op == opEret) begin
            expK = kcEret;
            mExl = 1'b0;
            mCode = excNone;
            mBd = 1'b0;
        end else if (!fl && req.op == opMtc0) begin
            if (req.instr.r.rd == cp0Sr) begin
                mIm = rt[15:10];
                mExl = rt[1];
                mIe = rt[0];
            end else if (req.instr.r.rd == cp0Epc) begin
                mEpc = rt[31:2];
            end
        end else if (!fl && isSt && inRam) begin
            // Byte by byte merge of the store into the image
            for (int b = 0; b < 4; b++) begin
                if (req.op == opSw) begin
                    word[8*b +: 8] = rt[8*b +: 8];
                end else if (req.op == opSh && b / 2 == int'(a[1])) begin
                    word[8*b +: 8] = rt[8*(b % 2) +: 8];
                end else if (req.op == opSb && b == int'(a[1:0])) begin
                    word[8*b +: 8] = rt[7:0];
                end
            end
            mdl[wIdx] = word;
        end
        return e;
    endfunction

    task automatic abortRun(input string why);
        $display("%s: %s", testName, why);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // Called at a falling edge, returns at the falling edge after the transfer
    task automatic sendReq(input memReq req, input logic fl);
        int waitCycles;
        memIn = req;
        inValid = 1'b1;
        flush = fl;
        #2;
        waitCycles = 0;
        while (!inReady && waitCycles < waitLimit) begin
            waitCycles++;
            @(negedge clk);
            #2;
        end
        if (!inReady) begin
            abortRun("inReady never rose for a pending request");
        end
        expQ.push_back(refStep(req, fl));
        lastK = kCtrl;
        lastEpc = epcOut;
        checks++;
        assert (kCtrl === expK && epcOut === expEpc && bdOut === expBd) else begin
            $display("FAILED %s: kCtrl/epc/bd expected %0d/%h/%b actual %0d/%h/%b",
                     testName, expK, expEpc, expBd, kCtrl, epcOut, bdOut);
            errors++;
        end
        @(negedge clk);
        inValid = 1'b0;
        flush = 1'b0;
    endtask

    task automatic checkKCtrl(input kernelCtrl want);
        checks++;
        assert (lastK === want) else begin
            $display("FAILED %s: kCtrl expected %0d actual %0d", testName, want, lastK);
            errors++;
        end
    endtask

    task automatic checkTrap(input memReq req);
        logic [31:0] want;
        want = req.inDelaySlot ? req.pc - 32'd4 : req.pc;
        checkKCtrl(kcKtext);
        checks++;
        assert (lastEpc === want[31:2]) else begin
            $display("FAILED %s: epcOut expected %h actual %h", testName, want[31:2], lastEpc);
            errors++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testChecks = checks;
        testErrors = errors;
    endtask

    task automatic finishTest();
        int waitCycles;
        waitCycles = 0;
        while (expQ.size() != 0 && waitCycles < waitLimit) begin
            waitCycles++;
            @(negedge clk);
        end
        if (expQ.size() != 0) begin
            abortRun("writeback entries still missing after the drain timeout");
        end
        tests++;
        $display("test %-10s %0d checks, %0d errors", testName, checks - testChecks,
                 errors - testErrors);
    endtask

    // Random stalls from the writeback side
    always @(negedge clk) begin
        if (gapsOn) begin
            gapSeed = lcgStep(gapSeed);
            outReady = gapSeed[17:16] != 2'b00;
        end else begin
            outReady = 1'b1;
        end
    end

    // Every output transfer pops one predicted entry
    always @(posedge clk) begin
        if (rst_n && outValid && outReady) begin
            checks++;
            assert (expQ.size() != 0) else begin
                $display("%s: an output transfer arrived with no entry expected", testName);
                errors++;
            end
            if (expQ.size() != 0) begin
                popped = expQ.pop_front();
                assert (wbOut === popped) else begin
                    $display("FAILED %s: wbEntry expected %h actual %h", testName, popped, wbOut);
                    errors++;
                end
            end
        end
    end

    task automatic storeTest();
        logic [31:0] r;
        logic [31:0] wAddr;
        startTest("stores");
        for (int i = 0; i < 16; i++) begin
            sendReq(buildReq(opSw, base + 32'(i * 4), 5'd4, nextRand(), 5'd0, 1'b0), 1'b0);
        end
        for (int i = 0; i < 40; i++) begin
            r = nextRand();
            wAddr = base + 32'({r[11:8], 2'b00});
            case (r[1:0])
                2'd0: sendReq(buildReq(opSb, wAddr + 32'(r[17:16]), 5'd4, nextRand(), 5'd0,
                                       1'b0), 1'b0);
                2'd1: sendReq(buildReq(opSh, wAddr + 32'({r[17], 1'b0}), 5'd4, nextRand(),
                                       5'd0, 1'b0), 1'b0);
                default: sendReq(buildReq(opSw, wAddr, 5'd4, nextRand(), 5'd0, 1'b0), 1'b0);
            endcase
            sendReq(buildReq(opLw, wAddr, 5'd2, 32'd0, 5'd0, 1'b0), 1'b0);
        end
        finishTest();
    endtask

    task automatic faultTest();
        memReq       req;
        memOp        fOps [6];
        logic [31:0] fAddr [6];
        startTest("faults");
        fOps = '{opLw, opSh, opLh, opLbu, opSw, opLw};
        fAddr = '{base + 32'd2, base + 32'd1, timer0Start, timer1Start + 32'd1, roAddr0,
                  32'h0000_9000};
        for (int i = 0; i < 7; i++) begin
            if (i < 6) begin
                req = buildReq(fOps[i], fAddr[i], 5'd4, nextRand(), 5'd0, i[0]);
            end else begin
                // Older fault from upstream must beat the misaligned load fault
                req = buildReq(opLw, base + 32'd2, 5'd4, 32'd0, 5'd0, 1'b1);
                req.hasExc = 1'b1;
                req.excIn = 5'd10;
            end
            sendReq(req, 1'b0);
            checkTrap(req);
            sendReq(buildReq(opMfc0, base, 5'd0, 32'd0, cp0Cause, 1'b0), 1'b0);
            sendReq(buildReq(opEret, base, 5'd0, 32'd0, 5'd0, 1'b0), 1'b0);
            checkKCtrl(kcEret);
        end
        sendReq(buildReq(opLw, base, 5'd2, 32'd0, 5'd0, 1'b0), 1'b0);
        finishTest();
    endtask

    task automatic cp0Test();
        startTest("cp0");
        sendReq(buildReq(opMtc0, base, 5'd8, 32'h0000_A801, cp0Sr, 1'b0), 1'b0);
        sendReq(buildReq(opMfc0, base, 5'd0, 32'd0, cp0Sr, 1'b0), 1'b0);
        sendReq(buildReq(opMtc0, base, 5'd8, 32'h0000_3ABC, cp0Epc, 1'b0), 1'b0);
        sendReq(buildReq(opMfc0, base, 5'd0, 32'd0, cp0Epc, 1'b0), 1'b0);
        sendReq(buildReq(opMfc0, base, 5'd0, 32'd0, cp0PrId, 1'b0), 1'b0);
        sendReq(buildReq(opMfc0, base, 5'd0, 32'd0, 5'd3, 1'b0), 1'b0);
        sendReq(buildReq(opMtc0, base, 5'd8, 32'h0000_FC01, cp0Sr, 1'b0), 1'b0);
        finishTest();
    endtask

    task automatic irqTest();
        startTest("interrupts");
        sendReq(buildReq(opMtc0, base, 5'd8, 32'h0000_F801, cp0Sr, 1'b0), 1'b0);
        hwInt = 6'b000001;
        sendReq(buildReq(opAlu, base, 5'd0, 32'd0, 5'd0, 1'b0), 1'b0);
        checkKCtrl(kcNone);
        sendReq(buildReq(opMtc0, base, 5'd8, 32'h0000_FC00, cp0Sr, 1'b0), 1'b0);
        sendReq(buildReq(opAlu, base, 5'd0, 32'd0, 5'd0, 1'b0), 1'b0);
        checkKCtrl(kcNone);
        sendReq(buildReq(opMtc0, base, 5'd8, 32'h0000_FC01, cp0Sr, 1'b0), 1'b0);
        sendReq(buildReq(opAlu, base, 5'd0, 32'd0, 5'd0, 1'b0), 1'b0);
        checkKCtrl(kcKtext);
        // EXL holds off a second entry
        sendReq(buildReq(opAlu, base, 5'd0, 32'd0, 5'd0, 1'b0), 1'b0);
        checkKCtrl(kcNone);
        sendReq(buildReq(opMfc0, base, 5'd0, 32'd0, cp0Cause, 1'b0), 1'b0);
        hwInt = 6'b000000;
        sendReq(buildReq(opEret, base, 5'd0, 32'd0, 5'd0, 1'b0), 1'b0);
        checkKCtrl(kcEret);
        hwInt = 6'b000001;
        sendReq(buildReq(opAlu, base, 5'd0, 32'd0, 5'd0, 1'b1), 1'b0);
        checkKCtrl(kcKtext);
        hwInt = 6'b000000;
        sendReq(buildReq(opEret, base, 5'd0, 32'd0, 5'd0, 1'b0), 1'b0);
        finishTest();
    endtask

    task automatic fwdTest();
        startTest("forwarding");
        fwd.addr = 5'd9;
        fwd.data = nextRand();
        sendReq(buildReq(opSw, base + 32'd8, 5'd9, nextRand(), 5'd0, 1'b0), 1'b0);
        fwd.addr = 5'd0;
        sendReq(buildReq(opLw, base + 32'd8, 5'd2, 32'd0, 5'd0, 1'b0), 1'b0);
        sendReq(buildReq(opSw, base + 32'd12, 5'd0, nextRand(), 5'd0, 1'b0), 1'b0);
        sendReq(buildReq(opLw, base + 32'd12, 5'd2, 32'd0, 5'd0, 1'b0), 1'b0);
        fwd = '0;
        finishTest();
    endtask

    task automatic stallTest();
        logic [31:0] r;
        logic [31:0] addr;
        memOp        op;
        startTest("stalls");
        gapsOn = 1'b1;
        sendReq(buildReq(opSw, base + 32'd16, 5'd5, nextRand(), 5'd0, 1'b0), 1'b1);
        for (int i = 0; i < 60; i++) begin
            r = nextRand();
            addr = base + 32'({r[11:8], 2'b00});
            case (r[2:0])
                3'd0, 3'd1: op = opSw;
                3'd2: begin
                    op = opSh;
                    addr = addr + 32'({r[17], 1'b0});
                end
                3'd3: begin
                    op = opSb;
                    addr = addr + 32'(r[17:16]);
                end
                3'd4, 3'd5: op = opLw;
                3'd6: begin
                    op = opLbu;
                    addr = addr + 32'(r[17:16]);
                end
                default: op = opAlu;
            endcase
            sendReq(buildReq(op, addr, 5'd5, nextRand(), 5'd0, 1'b0), r[22:20] == 3'd0);
        end
        gapsOn = 1'b0;
        for (int i = 0; i < 16; i++) begin
            sendReq(buildReq(opLw, base + 32'(i * 4), 5'd2, 32'd0, 5'd0, 1'b0), 1'b0);
        end
        finishTest();
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        memIn = '0;
        inValid = 1'b0;
        fwd = '0;
        flush = 1'b0;
        hwInt = '0;
        outReady = 1'b1;
        gapsOn = 1'b0;
        stimSeed = 32'h359d;
        gapSeed = 32'h359d;
        pcNext = epcReset;
        checks = 0;
        errors = 0;
        tests = 0;
        testName = "reset";
        mIm = '1;
        mExl = 1'b0;
        mIe = 1'b1;
        mIp = '0;
        mCode = excNone;
        mBd = 1'b0;
        mEpc = epcReset[31:2];
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        storeTest();
        faultTest();
        cp0Test();
        irqTest();
        fwdTest();
        stallTest();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
design/mipsIsaPkg.sv
design/memMapPkg.sv
design/storeLanes.sv
design/cp0Regs.sv
design/dataRam.sv
design/memStage.sv
design/memTop.sv
bench/memTopTb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := memTopTb
FILELIST  := src.f

OBJDIR  := obj_dir
SIM_BIN := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJDIR)
